// File: eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// clock cycles per quarter of an scl bit, at least 2
`define EE_QUARTER_CYCLES 4

// 24C16 device type code, upper nibble of the control byte
`define EE_DEVICE_CODE 4'b1010

// 2 KB array: 3 block bits plus 8 word bits
`define EE_ADDR_W 11

`endif

// File: eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // conditions and bits the engine can put on the wire
    typedef enum logic [1:0] {
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_cmd_t;

    typedef enum logic {
        BYTE_SEND,   // 8 out, ack in
        BYTE_RECV    // 8 in, ack out
    } byte_cmd_t;

    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] block;
        logic       rw;        // 1 = read
    } ctrl_fields_t;

    typedef union packed {
        ctrl_fields_t fields;
        logic [7:0]   raw;
    } ctrl_byte_u;

    typedef enum logic [3:0] {
        S_IDLE, S_START, S_CTRL_W, S_ADDR, S_DATA,
        S_RESTART, S_CTRL_R, S_READ, S_STOP, S_DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: i2c_bit_if.sv
`default_nettype none

interface i2c_bit_if;
    import eeprom_pkg::*;

    logic     go;
    bit_cmd_t cmd;
    logic     tx_bit;
    logic     rx_bit;    // bus level at the scl-high sample point
    logic     done;

    modport shifter (output go, output cmd, output tx_bit,
                     input rx_bit, input done);

    modport engine (input go, input cmd, input tx_bit,
                    output rx_bit, output done);

endinterface

`default_nettype wire

// File: i2c_byte_if.sv
`default_nettype none

interface i2c_byte_if;
    import eeprom_pkg::*;

    logic       go;
    byte_cmd_t  cmd;
    logic [7:0] tx_byte;
    logic       ack_send;    // 0 = acknowledge
    logic [7:0] rx_byte;
    logic       ack_seen;
    logic       done;
    logic       cond_go;     // start/stop request, passed through the shifter
    logic       cond_stop;   // 1 = stop, 0 = start

    modport seq (output go, output cmd, output tx_byte, output ack_send,
                 output cond_go, output cond_stop,
                 input rx_byte, input ack_seen, input done);

    modport shifter (input go, input cmd, input tx_byte, input ack_send,
                     input cond_go, input cond_stop,
                     output rx_byte, output ack_seen, output done);

endinterface

`default_nettype wire

// File: i2c_bit_engine.sv
`default_nettype none
`include "eeprom_defs.svh"

module i2c_bit_engine (
    input  wire logic  CLK,
    input  wire logic  RESET,
    i2c_bit_if.engine  bus,
    input  wire logic  sda_in,
    output logic       scl,
    output logic       sda_low
);
    import eeprom_pkg::*;

    localparam int QC = `EE_QUARTER_CYCLES;
    localparam int QW = $clog2(QC);

    logic          active;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;     // which quarter of the bit
    logic          q_last;
    bit_cmd_t      cmd_r;
    logic          rx_r;
    logic          done_r;

    assign q_last     = (qcnt == QW'(QC - 1));
    assign bus.rx_bit = rx_r;
    assign bus.done   = done_r;

    always_ff @(posedge CLK) begin
        if (!active && bus.go)
            cmd_r <= bus.cmd;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active  <= 1'b0;
            qcnt    <= '0;
            phase   <= 2'd0;
            scl     <= 1'b1;    // bus released
            sda_low <= 1'b0;
            rx_r    <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (!active) begin
                if (bus.go) begin
                    active <= 1'b1;
                    qcnt   <= '0;
                    phase  <= 2'd0;
                    // quarter 0 levels
                    case (bus.cmd)
                        BIT_START: sda_low <= 1'b0;   // scl left as it is
                        BIT_STOP: begin
                            scl     <= 1'b0;
                            sda_low <= 1'b1;
                        end
                        BIT_WRITE: begin
                            scl     <= 1'b0;
                            sda_low <= ~bus.tx_bit;
                        end
                        default: begin                // read, release sda
                            scl     <= 1'b0;
                            sda_low <= 1'b0;
                        end
                    endcase
                end
            end else if (q_last) begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                case (phase)
                    2'd0: scl <= 1'b1;
                    2'd1: begin
                        if (cmd_r == BIT_WRITE || cmd_r == BIT_READ)
                            rx_r <= sda_in;           // scl-high centre
                        if (cmd_r == BIT_START)
                            sda_low <= 1'b1;          // start edge
                        else if (cmd_r == BIT_STOP)
                            sda_low <= 1'b0;          // stop edge
                    end
                    2'd2: begin
                        if (cmd_r != BIT_STOP)
                            scl <= 1'b0;
                    end
                    default: begin
                        active <= 1'b0;
                        done_r <= 1'b1;
                    end
                endcase
            end else begin
                qcnt <= qcnt + QW'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: i2c_byte_shifter.sv
`default_nettype none

module i2c_byte_shifter (
    input  wire logic    CLK,
    input  wire logic    RESET,
    i2c_byte_if.shifter  host,
    i2c_bit_if.shifter   bits
);
    import eeprom_pkg::*;

    byte_cmd_t  cmd_r;
    logic       ack_send_r;
    logic [7:0] shreg;
    logic [3:0] bit_cnt;     // 0..7 data, 8 ack slot
    logic       in_byte;
    logic       in_cond;
    logic       go_r;
    bit_cmd_t   bcmd_r;
    logic       btx_r;
    logic       accept;
    logic       cond_accept;
    logic       step;

    assign accept      = !in_byte && !in_cond && host.go;
    assign cond_accept = !in_byte && !in_cond && !host.go && host.cond_go;
    assign step        = in_byte && bits.done && (bit_cnt != 4'd8);

    assign bits.go     = go_r;
    assign bits.cmd    = bcmd_r;
    assign bits.tx_bit = btx_r;

    assign host.rx_byte  = shreg;
    assign host.ack_seen = ~bits.rx_bit;    // slave held sda low
    assign host.done     = bits.done && (in_cond || (in_byte && bit_cnt == 4'd8));

    // payload and next bit command
    always_ff @(posedge CLK) begin
        if (accept) begin
            cmd_r      <= host.cmd;
            ack_send_r <= host.ack_send;
            shreg      <= host.tx_byte;
            bcmd_r     <= (host.cmd == BYTE_SEND) ? BIT_WRITE : BIT_READ;
            btx_r      <= (host.cmd == BYTE_SEND) ? host.tx_byte[7] : 1'b1;
        end else if (cond_accept) begin
            bcmd_r <= host.cond_stop ? BIT_STOP : BIT_START;
            btx_r  <= 1'b1;
        end else if (step) begin
            shreg <= {shreg[6:0], bits.rx_bit};   // a sent byte reads back too
            if (bit_cnt == 4'd7) begin
                bcmd_r <= (cmd_r == BYTE_SEND) ? BIT_READ : BIT_WRITE;
                btx_r  <= (cmd_r == BYTE_SEND) ? 1'b1 : ack_send_r;
            end else begin
                bcmd_r <= (cmd_r == BYTE_SEND) ? BIT_WRITE : BIT_READ;
                btx_r  <= (cmd_r == BYTE_SEND) ? shreg[6] : 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            in_byte <= 1'b0;
            in_cond <= 1'b0;
            bit_cnt <= 4'd0;
            go_r    <= 1'b0;
        end else begin
            go_r <= accept || cond_accept || step;
            if (accept) begin
                in_byte <= 1'b1;
                bit_cnt <= 4'd0;
            end else if (cond_accept) begin
                in_cond <= 1'b1;
            end else if (step) begin
                bit_cnt <= bit_cnt + 4'd1;
            end else if (bits.done) begin
                in_byte <= 1'b0;
                in_cond <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: eeprom_sequencer.sv
`default_nettype none
`include "eeprom_defs.svh"

module eeprom_sequencer (
    input  wire logic                  CLK,
    input  wire logic                  RESET,
    input  wire logic                  wr,
    input  wire logic                  rd,
    input  wire logic [`EE_ADDR_W-1:0] addr,
    input  wire logic [7:0]            wr_data,
    output logic [7:0]                 rd_data,
    output logic                       busy,
    output logic                       ack,
    output logic                       error,
    i2c_byte_if.seq                    byte_bus
);
    import eeprom_pkg::*;

    seq_state_t            state;
    logic                  sent;       // this state's command is out
    logic                  op_rd;
    logic                  fail;       // sticky, no ack somewhere
    logic                  go_r;
    logic                  cond_go_r;
    logic [`EE_ADDR_W-1:0] addr_r;
    logic [7:0]            data_r;
    ctrl_byte_u            ctrl;
    logic                  accept;
    logic                  is_cond;

    assign accept  = !busy && (wr || rd);
    assign is_cond = (state == S_START) || (state == S_RESTART) || (state == S_STOP);

    always_comb begin
        ctrl.fields.dev_code = `EE_DEVICE_CODE;
        ctrl.fields.block    = addr_r[10:8];
        ctrl.fields.rw       = (state == S_CTRL_R);
    end

    assign byte_bus.go        = go_r;
    assign byte_bus.cond_go   = cond_go_r;
    assign byte_bus.cond_stop = (state == S_STOP);
    assign byte_bus.cmd       = (state == S_READ) ? BYTE_RECV : BYTE_SEND;
    assign byte_bus.ack_send  = (state == S_READ);     // nack the only data byte

    always_comb begin
        case (state)
            S_ADDR:  byte_bus.tx_byte = addr_r[7:0];
            S_DATA:  byte_bus.tx_byte = data_r;
            default: byte_bus.tx_byte = ctrl.raw;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (state == S_IDLE && accept) begin
            addr_r <= addr;
            data_r <= wr_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= S_IDLE;
            sent      <= 1'b0;
            op_rd     <= 1'b0;
            fail      <= 1'b0;
            go_r      <= 1'b0;
            cond_go_r <= 1'b0;
            busy      <= 1'b0;
            ack       <= 1'b0;
            error     <= 1'b0;
            rd_data   <= 8'h00;
        end else begin
            go_r      <= 1'b0;
            cond_go_r <= 1'b0;
            ack       <= 1'b0;
            error     <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (busy) begin
                        busy <= 1'b0;           // ack cycle
                    end else if (accept) begin
                        op_rd <= !wr;           // write wins
                        fail  <= 1'b0;
                        busy  <= 1'b1;
                        state <= S_START;
                    end
                end
                S_DONE: begin
                    ack   <= 1'b1;
                    error <= fail;
                    state <= S_IDLE;
                end
                default: begin
                    if (!sent) begin
                        sent <= 1'b1;
                        if (is_cond)
                            cond_go_r <= 1'b1;
                        else
                            go_r <= 1'b1;
                    end else if (byte_bus.done) begin
                        sent <= 1'b0;
                        case (state)
                            S_START:   state <= S_CTRL_W;
                            S_CTRL_W:  state <= S_ADDR;
                            S_ADDR:    state <= op_rd ? S_RESTART : S_DATA;
                            S_DATA:    state <= S_STOP;
                            S_RESTART: state <= S_CTRL_R;
                            S_CTRL_R:  state <= S_READ;
                            S_READ: begin
                                rd_data <= byte_bus.rx_byte;
                                state   <= S_STOP;
                            end
                            default:   state <= S_DONE;
                        endcase
                        // memory silent, abort to stop
                        if (!is_cond && state != S_READ && !byte_bus.ack_seen) begin
                            fail  <= 1'b1;
                            state <= S_STOP;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: eeprom_wr.sv
`default_nettype none
`include "eeprom_defs.svh"

module eeprom_wr (
    input  wire logic                  CLK,
    input  wire logic                  RESET,
    input  wire logic                  wr,
    input  wire logic                  rd,
    input  wire logic [`EE_ADDR_W-1:0] addr,
    input  wire logic [7:0]            wr_data,
    output logic [7:0]                 rd_data,
    output logic                       busy,
    output logic                       ack,
    output logic                       error,
    output logic                       scl,
    output logic                       sda_low,    // open-drain pull-down
    input  wire logic                  sda_in
);

    i2c_bit_if  bit_bus ();
    i2c_byte_if byte_bus ();

    eeprom_sequencer u_seq (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .busy     (busy),
        .ack      (ack),
        .error    (error),
        .byte_bus (byte_bus)
    );

    i2c_byte_shifter u_shift (
        .CLK   (CLK),
        .RESET (RESET),
        .host  (byte_bus),
        .bits  (bit_bus)
    );

    i2c_bit_engine u_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .bus     (bit_bus),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_low (sda_low)
    );

endmodule

`default_nettype wire

// File: eeprom_model.sv
`default_nettype none
`include "eeprom_defs.svh"

module eeprom_model (
    input  wire logic scl,
    input  wire logic sda,
    input  wire logic present,      // low: device absent, never acks
    output logic      pull,         // open-drain pull-down on sda
    output logic      protocol_err
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem [0:2047];
    logic [7:0]  shreg;
    logic [7:0]  tx_sh;
    logic [10:0] ptr;           // block and word
    logic        scl_q;
    logic        sda_q;
    logic        active;
    logic        skip_fall;     // scl fall that closes a start
    logic        sel;
    logic        rd_mode;
    logic        mack;          // sda in the ack slot
    int          bit_cnt;
    int          byte_idx;

    // end of bit 7 of a byte sent by the master
    task automatic take_byte();
        if (byte_idx == 0) begin
            sel = present && (shreg[7:4] == `EE_DEVICE_CODE);
            if (sel) begin
                ptr[10:8] = shreg[3:1];
                rd_mode   = shreg[0];
            end
        end else if (sel && byte_idx == 1) begin
            ptr[7:0] = shreg;
        end else if (sel) begin
            mem[ptr] = shreg;
            ptr[7:0] = ptr[7:0] + 8'd1;
        end
        pull     = sel;
        byte_idx = byte_idx + 1;
    endtask

    initial begin
        logic [10:0] fill_a;
        for (int i = 0; i < 2048; i++) begin
            fill_a      = 11'(i);
            mem[fill_a] = fill_a[7:0] ^ {fill_a[10:8], 5'h0b};
        end
        pull         = 1'b0;
        protocol_err = 1'b0;
        active       = 1'b0;
        skip_fall    = 1'b0;
        sel          = 1'b0;
        rd_mode      = 1'b0;
        mack         = 1'b1;
        bit_cnt      = 0;
        byte_idx     = 0;
        shreg        = 8'h00;
        tx_sh        = 8'h00;
        ptr          = 11'h000;
        scl_q        = scl;
        sda_q        = sda;
        forever begin
            @(scl or sda);
            if (scl_q === 1'b1 && scl === 1'b1 && sda_q !== sda) begin
                // sda moved under a high scl, only legal between bytes
                if (active && bit_cnt != 0)
                    protocol_err = 1'b1;
                active  = (sda === 1'b0);   // start, else stop
                sel     = 1'b0;
                rd_mode = 1'b0;
                pull    = 1'b0;
                if (active) begin
                    skip_fall = 1'b1;
                    bit_cnt   = 0;
                    byte_idx  = 0;
                end
            end else if (active && scl_q === 1'b0 && scl === 1'b1) begin
                if (bit_cnt == 8)
                    mack = sda;
                else
                    shreg = {shreg[6:0], sda};
            end else if (active && scl_q === 1'b1 && scl === 1'b0) begin
                if (skip_fall) begin
                    skip_fall = 1'b0;
                end else if (bit_cnt < 7) begin
                    bit_cnt = bit_cnt + 1;
                    if (sel && rd_mode) begin
                        tx_sh = {tx_sh[6:0], 1'b0};
                        pull  = ~tx_sh[7];
                    end
                end else if (bit_cnt == 7) begin
                    bit_cnt = 8;
                    if (sel && rd_mode) begin
                        pull     = 1'b0;            // master's ack slot
                        ptr[7:0] = ptr[7:0] + 8'd1;
                    end else begin
                        take_byte();
                    end
                end else begin
                    bit_cnt = 0;
                    pull    = 1'b0;
                    if (sel && rd_mode) begin
                        if (mack == 1'b0) begin
                            tx_sh = mem[ptr];
                            pull  = ~tx_sh[7];
                        end else begin
                            sel = 1'b0;             // nack ends the read
                        end
                    end
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

// File: tb_eeprom_wr.sv
`default_nettype none
`include "eeprom_defs.svh"

module tb_eeprom_wr;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] OP_IDLE = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_RD   = 2'd2;
    localparam int MAX_ROWS = 32;
    localparam int BIT_CYC  = 4 * `EE_QUARTER_CYCLES + 1;

    typedef struct packed {
        logic [1:0]  op;
        logic [10:0] addr;
        logic [7:0]  data;
        logic        present;
        logic [7:0]  exp_rd;
        logic        exp_err;
    } row_t;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wr_data;
    logic [7:0]  rd_data;
    logic        busy;
    logic        ack;
    logic        error;
    logic        scl;
    logic        sda_low;
    logic        present;
    logic        model_pull;
    logic        protocol_err;
    wire logic   sda;
    row_t        rows [MAX_ROWS];
    logic [7:0]  ref_mem [0:2047];
    logic [7:0]  last_rd;
    logic [31:0] lcg;
    int          n_rows = 0;
    int          acks = 0;

    assign sda = ~(sda_low | model_pull);   // wired-and bus

    eeprom_wr uut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr),
        .wr_data(wr_data), .rd_data(rd_data), .busy(busy), .ack(ack),
        .error(error), .scl(scl), .sda_low(sda_low), .sda_in(sda)
    );

    eeprom_model u_mem (
        .scl(scl), .sda(sda), .present(present), .pull(model_pull),
        .protocol_err(protocol_err)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (ack === 1'b1)
            acks <= acks + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic check_hex(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // expected values follow the reference array
    task automatic add_row(input logic [1:0] op, input logic [10:0] a,
                           input logic [7:0] d, input logic p);
        row_t r;
        if (op == OP_WR && p)
            ref_mem[a] = d;
        if (op == OP_RD && p)
            last_rd = ref_mem[a];
        r.op      = op;
        r.addr    = a;
        r.data    = d;
        r.present = p;
        r.exp_rd  = last_rd;
        r.exp_err = (op != OP_IDLE) && !p;
        rows[n_rows] = r;
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        logic [10:0] lcg_addr [10];
        last_rd = 8'h00;
        lcg     = 32'd48651;
        add_row(OP_WR, 11'h0f3, 8'ha5, 1'b1);     // block 0
        add_row(OP_RD, 11'h0f3, 8'h00, 1'b1);
        add_row(OP_WR, 11'h7f3, 8'h3c, 1'b1);     // block 7, same word
        add_row(OP_RD, 11'h7f3, 8'h00, 1'b1);
        add_row(OP_RD, 11'h0f3, 8'h00, 1'b1);
        add_row(OP_IDLE, 11'h000, 8'h00, 1'b1);
        for (int i = 0; i < 10; i++) begin
            lcg         = lcg_next(lcg);
            lcg_addr[i] = lcg[26:16];
            lcg         = lcg_next(lcg);
            add_row(OP_WR, lcg_addr[i], lcg[23:16], 1'b1);
        end
        for (int i = 0; i < 10; i++)
            add_row(OP_RD, lcg_addr[(i * 3) % 10], 8'h00, 1'b1);
        // no device on the bus
        add_row(OP_WR, 11'h7f3, 8'hff, 1'b0);
        add_row(OP_RD, 11'h005, 8'h00, 1'b0);
        add_row(OP_RD, 11'h7f3, 8'h00, 1'b1);
    endtask

    task automatic run_row(input row_t r);
        int acks_before;
        int acks_exp;
        acks_before = acks;
        acks_exp    = acks_before + ((r.op == OP_IDLE) ? 0 : 1);
        present     = r.present;
        if (r.op == OP_IDLE) begin
            repeat (20) @(posedge CLK);
            #1;
        end else begin
            addr    = r.addr;
            wr_data = r.data;
            wr      = (r.op == OP_WR);
            rd      = (r.op == OP_RD);
            @(posedge CLK);
            #1;
            wr = 1'b0;
            rd = 1'b0;
            @(posedge CLK);
            #1;
            assert (busy === 1'b1) else begin
                $display("busy did not rise after a request");
                abort_run();
            end
            while (ack !== 1'b1) begin
                @(posedge CLK);
                #1;
            end
            check_hex("error", 8'(error), 8'(r.exp_err));
            check_hex("busy", 8'(busy), 8'h01);
            wr      = 1'b1;           // stray request in the ack cycle
            addr    = ~r.addr;
            wr_data = 8'hee;
            @(posedge CLK);
            #1;
            wr = 1'b0;
            check_hex("busy", 8'(busy), 8'h00);
            repeat (4) @(posedge CLK);
            #1;
        end
        check_hex("rd_data", rd_data, r.exp_rd);
        assert (acks == acks_exp) else begin
            $display("CHECK FAILED ack count: got %h, expected %h", acks, acks_exp);
            abort_run();
        end
        assert (protocol_err === 1'b0) else begin
            $display("the memory model saw sda change while scl was high inside a byte");
            abort_run();
        end
    endtask

    initial begin
        longint limit;
        wait (n_rows != 0);
        limit = longint'(n_rows) * 39 * BIT_CYC * 4 * 2;
        #(limit);
        $display("timeout: the tests did not finish within %0d ns", limit);
        abort_run();
    end

    initial begin
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = 11'h000;
        wr_data = 8'h00;
        present = 1'b1;
        build_table();
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        check_hex("scl", 8'(scl), 8'h01);         // bus released
        check_hex("sda_low", 8'(sda_low), 8'h00);
        check_hex("busy", 8'(busy), 8'h00);
        check_hex("ack", 8'(ack), 8'h00);
        check_hex("error", 8'(error), 8'h00);
        check_hex("rd_data", rd_data, 8'h00);
        for (int i = 0; i < n_rows; i++)
            run_row(rows[i]);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
eeprom_pkg.sv
i2c_bit_if.sv
i2c_byte_if.sv
i2c_bit_engine.sv
i2c_byte_shifter.sv
eeprom_sequencer.sv
eeprom_wr.sv
eeprom_model.sv
tb_eeprom_wr.sv

// File: run.sh
#!/bin/sh
# build and run the EEPROM master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f filelist.f --top-module tb_eeprom_wr
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_eeprom_wr
status=$?
if [ $status -ne 0 ]; then
    echo "simulation reported failure"
fi
exit $status
